// File: run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f sources.f \
  --top-module priv_unit_tb \
  --Mdir obj_dir \
  -o Vpriv_unit_tb

./obj_dir/Vpriv_unit_tb 2>&1 | tee sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
  echo "simulation reported failures, see sim.log"
  exit 1
fi

grep -q "ALL TESTS PASSED" sim.log

// File: sim/priv_unit_props.sv
// Concurrent checks on the host credit flow and on trap entry winning over mret, bound into priv_unit
`timescale 1ns/1ps
`default_nettype none

module priv_unit_props #(
  parameter int CREDITS = machine_mode_pkg::TOHOST_CREDITS,
  parameter int CRD_W   = $clog2(CREDITS + 1)
) (
  input wire logic             CLK,
  input wire logic             nRST,
  input wire logic [CRD_W-1:0] credits,
  input wire logic             host_valid,
  input wire logic             host_credit,
  input wire logic             trap_taken,
  input wire logic             mstatus_ie,
  input wire logic             mstatus_ie1
);

  // Failed checks so far
  int fail_count = 0;
  // Words sent and not yet credited back, seen at the host ports
  int in_flight;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      in_flight <= 0;
    end else begin
      in_flight <= in_flight + int'(host_valid) - int'(host_credit);
    end
  end

  // Host never returns more credits than slots
  a_credit_max: assert property (@(posedge CLK) disable iff (!nRST)
    32'(credits) <= CREDITS)
    else begin
      $error("credit count above the host buffer size");
      fail_count++;
    end

  // No send while every host slot is taken
  a_valid_needs_credit: assert property (@(posedge CLK) disable iff (!nRST)
    host_valid |-> in_flight < CREDITS)
    else begin
      $error("host_valid high with zero credits");
      fail_count++;
    end

  // Trap pushes the enable stack, so a same-cycle mret never pops it
  a_trap_over_mret: assert property (@(posedge CLK) disable iff (!nRST)
    trap_taken |=> !mstatus_ie && (mstatus_ie1 == $past(mstatus_ie)))
    else begin
      $error("trap entry did not push the enable stack");
      fail_count++;
    end

endmodule

bind priv_unit priv_unit_props props_i (
  .CLK         (CLK),
  .nRST        (nRST),
  .credits     (tohost_link_i.credits),
  .host_valid  (tohost_link_i.host_valid),
  .host_credit (host_credit),
  .trap_taken  (prv_control_i.trap_taken),
  .mstatus_ie  (csr_rfile_i.mstatus_ie),
  .mstatus_ie1 (csr_rfile_i.mstatus_ie1)
);

`default_nettype wire

// File: sim/priv_unit_tb.sv
// Testbench top for priv_unit, drives CSR, trap and host traffic against a reference model
`timescale 1ns/1ps
`default_nettype none

module priv_unit_tb;

  localparam int DEPTH   = machine_mode_pkg::TOHOST_DEPTH;
  localparam int CREDITS = machine_mode_pkg::TOHOST_CREDITS;
  // Tests 1..6 roughly 30+15+20+20+200+5 cycles, plus margin
  localparam int TIMEOUT_CYCLES = 400;

  logic CLK, nRST;
  machine_mode_pkg::csr_addr_t csr_addr;
  machine_mode_pkg::word_t     csr_wdata, exc_pc, exc_badaddr, fromhost_data;
  logic csr_swap, csr_set, csr_clr, mret, irq_soft, irq_timer;
  logic exc_illegal, exc_breakpoint, exc_ecall, exc_load_misaligned, exc_store_misaligned;
  logic host_credit, fromhost_valid;
  machine_mode_pkg::word_t csr_rdata, redirect_pc, host_data;
  logic invalid_csr, csr_busy, trap_taken, host_valid;

  // Expected values and check enables
  machine_mode_pkg::word_t exp_rdata, exp_redirect;
  logic chk_rdata, chk_redirect, exp_trap, exp_invalid;
  // Reference state
  logic m_ie = 1'b1;
  logic m_ie1 = 1'b0;
  machine_mode_pkg::word_t m_scratch, m_mie, m_epc, m_badaddr, m_front, w;
  machine_mode_pkg::cause_t m_cause;
  machine_mode_pkg::word_t m_q [$];
  int  m_credits = CREDITS;
  logic m_valid, m_full, tohost_wr, accepted;
  logic send, push;
  int  errors, test_start_errs, tests_failed, cycles;
  int  seed = 24742;

  tb_clock_gen clk_gen_i (.CLK, .nRST);

  priv_unit priv_unit_i (.*);

  assign tohost_wr = (csr_swap | csr_set | csr_clr) &&
                     (csr_addr == machine_mode_pkg::MTOHOST_ADDR);

  // Outputs checked at the falling edge, well clear of the drive point
  a_rdata: assert property (@(negedge CLK) disable iff (!nRST)
    chk_rdata |-> csr_rdata == exp_rdata)
    else begin
      $display("** Error at %0t: csr 0x%h read 0x%h, expected 0x%h",
               $time, csr_addr, csr_rdata, exp_rdata);
      errors++;
    end
  a_invalid: assert property (@(negedge CLK) disable iff (!nRST)
    invalid_csr == exp_invalid)
    else begin
      $display("** Error at %0t: invalid_csr is %b", $time, invalid_csr);
      errors++;
    end
  a_trap: assert property (@(negedge CLK) disable iff (!nRST)
    trap_taken == exp_trap)
    else begin
      $display("** Error at %0t: trap_taken is %b", $time, trap_taken);
      errors++;
    end
  a_redirect: assert property (@(negedge CLK) disable iff (!nRST)
    chk_redirect |-> redirect_pc == exp_redirect)
    else begin
      $display("** Error at %0t: redirect_pc 0x%h, expected 0x%h",
               $time, redirect_pc, exp_redirect);
      errors++;
    end
  a_host_valid: assert property (@(negedge CLK) disable iff (!nRST)
    host_valid == m_valid)
    else begin
      $display("** Error at %0t: host_valid is %b", $time, host_valid);
      errors++;
    end
  a_host_data: assert property (@(negedge CLK) disable iff (!nRST)
    host_valid |-> host_data == m_front)
    else begin
      $display("** Error at %0t: host_data 0x%h, expected 0x%h", $time, host_data, m_front);
      errors++;
    end
  a_busy: assert property (@(negedge CLK) disable iff (!nRST)
    csr_busy == (tohost_wr && m_full))
    else begin
      $display("** Error at %0t: csr_busy is %b", $time, csr_busy);
      errors++;
    end

  // Host queue model and random credit return
  always @(posedge CLK) begin
    if (!nRST) begin
      m_q.delete();
      m_credits = CREDITS;
    end else begin
      send = m_valid;
      push = tohost_wr && !m_full;
      if (send) void'(m_q.pop_front());
      if (push) m_q.push_back(csr_wdata);
      m_credits = m_credits - int'(send) + int'(host_credit);
    end
    m_valid = (m_q.size() != 0) && (m_credits > 0);
    m_front = (m_q.size() != 0) ? m_q[0] : '0;
    m_full  = (m_q.size() == DEPTH);
    #1 host_credit = nRST && (m_credits < CREDITS) && (($random(seed) & 3) == 0);
  end

  always @(posedge CLK) begin
    cycles++;
    if (cycles > TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  function automatic machine_mode_pkg::word_t apply_op(int kind, machine_mode_pkg::word_t old,
                                                       machine_mode_pkg::word_t wd);
    // 0 swap, 1 set, 2 clear
    if (kind == 0) return wd;
    if (kind == 1) return old | wd;
    return old & ~wd;
  endfunction

  function automatic machine_mode_pkg::word_t mstatus_exp();
    machine_mode_pkg::word_t v;
    v = '0;
    v[machine_mode_pkg::MSTATUS_IE_BIT]  = m_ie;
    v[machine_mode_pkg::MSTATUS_IE1_BIT] = m_ie1;
    return v;
  endfunction

  function automatic machine_mode_pkg::word_t mie_mask();
    machine_mode_pkg::word_t v;
    v = '0;
    v[machine_mode_pkg::MIE_MSIE_BIT] = 1'b1;
    v[machine_mode_pkg::MIE_MTIE_BIT] = 1'b1;
    return v;
  endfunction

  // Failed checks so far, here and in the bound checker
  function automatic int error_total();
    return errors + priv_unit_i.props_i.fail_count;
  endfunction

  // Advance one cycle and return pipeline inputs to idle
  task automatic step();
    @(posedge CLK);
    #1;
    {csr_swap, csr_set, csr_clr, mret, fromhost_valid} = '0;
    {exc_illegal, exc_breakpoint, exc_ecall} = '0;
    {exc_load_misaligned, exc_store_misaligned} = '0;
    {chk_rdata, chk_redirect, exp_trap, exp_invalid} = '0;
  endtask

  task automatic read_expect(input machine_mode_pkg::csr_addr_t a,
                             input machine_mode_pkg::word_t v);
    step();
    csr_addr  = a;
    exp_rdata = v;
    chk_rdata = 1'b1;
  endtask

  task automatic csr_write(input int kind, input machine_mode_pkg::csr_addr_t a,
                           input machine_mode_pkg::word_t wd);
    step();
    csr_addr  = a;
    csr_wdata = wd;
    csr_swap  = (kind == 0);
    csr_set   = (kind == 1);
    csr_clr   = (kind == 2);
  endtask

  // Expect trap entry in the current cycle, update the model
  task automatic expect_trap(input machine_mode_pkg::cause_t cause, input logic misal);
    exp_trap     = 1'b1;
    chk_redirect = 1'b1;
    exp_redirect = machine_mode_pkg::MTVEC_ADDR;
    m_cause = cause;
    m_epc   = exc_pc;
    if (misal) m_badaddr = exc_badaddr;
    m_ie1 = m_ie;
    m_ie  = 1'b0;
  endtask

  task automatic do_mret();
    step();
    mret         = 1'b1;
    chk_redirect = 1'b1;
    exp_redirect = m_epc;
    m_ie  = m_ie1;
    m_ie1 = 1'b1;
  endtask

  task automatic check_trap_state();
    read_expect(machine_mode_pkg::MCAUSE_ADDR, m_cause);
    read_expect(machine_mode_pkg::MEPC_ADDR, m_epc);
    read_expect(machine_mode_pkg::MBADADDR_ADDR, m_badaddr);
    read_expect(machine_mode_pkg::MSTATUS_ADDR, mstatus_exp());
  endtask

  task automatic end_test(input string name);
    if (error_total() == test_start_errs) begin
      $display("Test %s: pass", name);
    end else begin
      $display("Test %s: fail (%0d errors)", name, error_total() - test_start_errs);
      tests_failed++;
    end
    test_start_errs = error_total();
  endtask

  initial begin
    csr_addr = '0;
    csr_wdata = '0;
    {csr_swap, csr_set, csr_clr, mret, irq_soft, irq_timer} = '0;
    {exc_illegal, exc_breakpoint, exc_ecall} = '0;
    {exc_load_misaligned, exc_store_misaligned} = '0;
    exc_pc = '0;
    exc_badaddr = '0;
    host_credit = 1'b0;
    fromhost_valid = 1'b0;
    fromhost_data = '0;
    {chk_rdata, chk_redirect, exp_trap, exp_invalid} = '0;
    exp_rdata = '0;
    exp_redirect = '0;
    {m_scratch, m_mie, m_epc, m_badaddr, m_cause} = '0;
    @(posedge nRST);

    // 1: constants, zero addresses, unknown address
    read_expect(machine_mode_pkg::MCPUID_ADDR, machine_mode_pkg::MCPUID_VALUE);
    read_expect(machine_mode_pkg::MTVEC_CSR_ADDR, machine_mode_pkg::MTVEC_ADDR);
    read_expect(machine_mode_pkg::MHARTID_ADDR, '0);
    for (int i = 0; i < machine_mode_pkg::NUM_ZERO_ADDRS; i++) begin
      read_expect(machine_mode_pkg::ZERO_ADDRS[i], '0);
    end
    exc_pc = 32'h0000_0040;
    csr_write(1, 12'h123, '0);
    exp_invalid = 1'b1;
    expect_trap(machine_mode_pkg::CAUSE_ILLEGAL_INSN, 1'b0);
    check_trap_state();
    do_mret();
    read_expect(machine_mode_pkg::MSTATUS_ADDR, mstatus_exp());
    end_test("1 constants and invalid address");

    // 2: swap, set, clear on mscratch and mie
    for (int k = 0; k < 3; k++) begin
      w = (k == 0) ? 32'hA5A5_0F0F : (k == 1) ? 32'h0000_F0F0 : 32'hA500_00FF;
      csr_write(k, machine_mode_pkg::MSCRATCH_ADDR, w);
      m_scratch = apply_op(k, m_scratch, w);
      read_expect(machine_mode_pkg::MSCRATCH_ADDR, m_scratch);
      w = (k == 0) ? 32'hFFFF_FFFF : (k == 1) ? 32'h0000_0008 : 32'h0000_0088;
      csr_write(2 - k, machine_mode_pkg::MIE_ADDR, w);
      m_mie = apply_op(2 - k, m_mie, w) & mie_mask();
      read_expect(machine_mode_pkg::MIE_ADDR, m_mie);
    end
    end_test("2 csr read-modify-write");

    // 3: exception ranking, mepc and mbadaddr, nested mret
    step();
    exc_pc = 32'h0000_1000;
    exc_badaddr = 32'h0000_2002;
    {exc_ecall, exc_store_misaligned, exc_breakpoint} = 3'b111;
    // Same-cycle mret is cancelled by the trap
    mret = 1'b1;
    expect_trap(machine_mode_pkg::CAUSE_BREAKPOINT, 1'b0);
    check_trap_state();
    step();
    exc_pc = 32'h0000_1100;
    exc_badaddr = 32'h0000_3001;
    {exc_load_misaligned, exc_store_misaligned, exc_ecall} = 3'b111;
    expect_trap(machine_mode_pkg::CAUSE_LOAD_MISALIGNED, 1'b1);
    check_trap_state();
    do_mret();
    do_mret();
    read_expect(machine_mode_pkg::MSTATUS_ADDR, mstatus_exp());
    end_test("3 exception priority and mret");

    // 4: timer interrupt masked by mie, then by ie, then taken
    csr_write(0, machine_mode_pkg::MIE_ADDR, '0);
    m_mie = '0;
    read_expect(machine_mode_pkg::MIP_ADDR, '0);
    irq_timer = 1'b1;
    read_expect(machine_mode_pkg::MIP_ADDR, 32'(1) << machine_mode_pkg::MIP_MTIP_BIT);
    csr_write(2, machine_mode_pkg::MSTATUS_ADDR, 32'h1);
    w = apply_op(2, mstatus_exp(), 32'h1);
    m_ie  = w[machine_mode_pkg::MSTATUS_IE_BIT];
    m_ie1 = w[machine_mode_pkg::MSTATUS_IE1_BIT];
    m_mie = 32'(1) << machine_mode_pkg::MIE_MTIE_BIT;
    csr_write(0, machine_mode_pkg::MIE_ADDR, m_mie);
    read_expect(machine_mode_pkg::MIE_ADDR, m_mie);
    csr_write(1, machine_mode_pkg::MSTATUS_ADDR, 32'h1);
    w = apply_op(1, mstatus_exp(), 32'h1);
    m_ie  = w[machine_mode_pkg::MSTATUS_IE_BIT];
    m_ie1 = w[machine_mode_pkg::MSTATUS_IE1_BIT];
    step();
    exc_pc = 32'h0000_0200;
    expect_trap(machine_mode_pkg::CAUSE_TIMER_INT, 1'b0);
    csr_write(2, machine_mode_pkg::MIE_ADDR, m_mie);
    irq_timer = 1'b0;
    m_mie = '0;
    check_trap_state();
    do_mret();
    end_test("4 timer interrupt");

    // 5: tohost stream under random credit return
    for (int i = 0; i < 8; i++) begin
      accepted = 1'b0;
      while (!accepted) begin
        csr_write(0, machine_mode_pkg::MTOHOST_ADDR, 32'h1000_0000 + 32'(i) * 32'h0101);
        accepted = !m_full;
      end
    end
    step();
    while (m_q.size() != 0 || m_credits != CREDITS) step();
    end_test("5 tohost flow control");

    // 6: fromhost delivery
    step();
    fromhost_valid = 1'b1;
    fromhost_data  = 32'hCAFE_F00D;
    read_expect(machine_mode_pkg::MFROMHOST_ADDR, 32'hCAFE_F00D);
    end_test("6 fromhost");

    step();
    step();
    $display("Summary: 6 tests, %0d failed, %0d check errors", tests_failed, error_total());
    if (error_total() == 0 && tests_failed == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sim/tb_clock_gen.sv
// Testbench clock and reset source, 100 ns period with reset held for four cycles
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic CLK,
  output logic nRST
);

  initial begin
    CLK  = 1'b0;
    nRST = 1'b0;
    // Release just after the fourth rising edge
    repeat (4) @(posedge CLK);
    #1 nRST = 1'b1;
  end

  always #50 CLK = ~CLK;

endmodule

`default_nettype wire

// File: source/csr_rfile.sv
// Machine CSR storage with the pipeline read/modify/write port, used inside priv_unit
`timescale 1ns/1ps
`default_nettype none

module csr_rfile (
  input  wire logic                        CLK,
  input  wire logic                        nRST,
  // Pipeline CSR port
  input  wire machine_mode_pkg::csr_addr_t csr_addr,
  input  wire machine_mode_pkg::word_t     csr_wdata,
  input  wire logic                        csr_swap,
  input  wire logic                        csr_set,
  input  wire logic                        csr_clr,
  output      machine_mode_pkg::word_t     csr_rdata,
  output      logic                        invalid_csr,
  output      logic                        csr_busy,
  // Interrupt lines
  input  wire logic                        irq_soft,
  input  wire logic                        irq_timer,
  // Updates from the privilege controller
  input  wire logic                        mcause_rup,
  input  wire machine_mode_pkg::cause_t    mcause_next,
  input  wire logic                        mepc_rup,
  input  wire machine_mode_pkg::word_t     mepc_next,
  input  wire logic                        mbadaddr_rup,
  input  wire machine_mode_pkg::word_t     mbadaddr_next,
  input  wire logic                        ie_rup,
  input  wire logic                        ie_next,
  input  wire logic                        ie1_next,
  output      logic                        mstatus_ie,
  output      logic                        mstatus_ie1,
  output      machine_mode_pkg::word_t     mie,
  output      machine_mode_pkg::word_t     mip,
  output      machine_mode_pkg::word_t     mepc,
  // Host side
  input  wire logic                        tohost_full,
  output      logic                        tohost_push,
  output      machine_mode_pkg::word_t     tohost_data,
  input  wire logic                        fromhost_valid,
  input  wire machine_mode_pkg::word_t     fromhost_data
);

  logic                     msie, mtie;
  logic                     msip, mtip;
  machine_mode_pkg::word_t  mscratch;
  machine_mode_pkg::cause_t mcause;
  machine_mode_pkg::word_t  mbadaddr;
  machine_mode_pkg::word_t  mtohost;
  machine_mode_pkg::word_t  mfromhost;
  machine_mode_pkg::word_t  mstatus;
  machine_mode_pkg::word_t  wr_value;
  logic                     csr_op;
  logic                     valid_addr;
  logic                     wr_tohost;

  // Assembled views of the sparse registers
  always_comb begin
    mstatus = '0;
    mstatus[machine_mode_pkg::MSTATUS_IE_BIT]  = mstatus_ie;
    mstatus[machine_mode_pkg::MSTATUS_IE1_BIT] = mstatus_ie1;
    mie = '0;
    mie[machine_mode_pkg::MIE_MSIE_BIT] = msie;
    mie[machine_mode_pkg::MIE_MTIE_BIT] = mtie;
    mip = '0;
    mip[machine_mode_pkg::MIP_MSIP_BIT] = msip;
    mip[machine_mode_pkg::MIP_MTIP_BIT] = mtip;
  end

  // Read mux and address decode
  always_comb begin
    valid_addr = 1'b1;
    csr_rdata  = '0;
    case (csr_addr)
      machine_mode_pkg::MCPUID_ADDR:    csr_rdata = machine_mode_pkg::MCPUID_VALUE;
      // Single hart, no version, no delegation
      machine_mode_pkg::MIMPID_ADDR,
      machine_mode_pkg::MHARTID_ADDR,
      machine_mode_pkg::MTDELEG_ADDR:   csr_rdata = '0;
      machine_mode_pkg::MSTATUS_ADDR:   csr_rdata = mstatus;
      machine_mode_pkg::MTVEC_CSR_ADDR: csr_rdata = machine_mode_pkg::MTVEC_ADDR;
      machine_mode_pkg::MIE_ADDR:       csr_rdata = mie;
      machine_mode_pkg::MSCRATCH_ADDR:  csr_rdata = mscratch;
      machine_mode_pkg::MEPC_ADDR:      csr_rdata = mepc;
      machine_mode_pkg::MCAUSE_ADDR:    csr_rdata = mcause;
      machine_mode_pkg::MBADADDR_ADDR:  csr_rdata = mbadaddr;
      machine_mode_pkg::MIP_ADDR:       csr_rdata = mip;
      machine_mode_pkg::MTOHOST_ADDR:   csr_rdata = mtohost;
      machine_mode_pkg::MFROMHOST_ADDR: csr_rdata = mfromhost;
      default: begin
        // Known but unimplemented addresses still decode
        valid_addr = 1'b0;
        for (int i = 0; i < machine_mode_pkg::NUM_ZERO_ADDRS; i++) begin
          if (csr_addr == machine_mode_pkg::ZERO_ADDRS[i]) begin
            valid_addr = 1'b1;
          end
        end
      end
    endcase
  end

  assign csr_op      = csr_swap | csr_set | csr_clr;
  assign invalid_csr = csr_op & ~valid_addr;

  // Swap, clear, otherwise set
  assign wr_value = csr_swap ? csr_wdata :
                    csr_clr  ? (csr_rdata & ~csr_wdata) :
                               (csr_rdata | csr_wdata);

  // Full host queue stalls the write until it drains
  assign wr_tohost   = csr_op && (csr_addr == machine_mode_pkg::MTOHOST_ADDR);
  assign csr_busy    = wr_tohost & tohost_full;
  assign tohost_push = wr_tohost & ~tohost_full;
  assign tohost_data = wr_value;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      mstatus_ie  <= 1'b1;
      mstatus_ie1 <= 1'b0;
      msie        <= 1'b0;
      mtie        <= 1'b0;
      msip        <= 1'b0;
      mtip        <= 1'b0;
      mscratch    <= '0;
      mepc        <= '0;
      mcause      <= '0;
      mbadaddr    <= '0;
      mtohost     <= '0;
      mfromhost   <= '0;
    end else begin
      // Interrupt lines sampled every cycle
      msip <= irq_soft;
      mtip <= irq_timer;

      // Trap entry and mret win over a pipeline write
      if (ie_rup) begin
        mstatus_ie  <= ie_next;
        mstatus_ie1 <= ie1_next;
      end else if (csr_op && csr_addr == machine_mode_pkg::MSTATUS_ADDR) begin
        mstatus_ie  <= wr_value[machine_mode_pkg::MSTATUS_IE_BIT];
        mstatus_ie1 <= wr_value[machine_mode_pkg::MSTATUS_IE1_BIT];
      end

      if (csr_op && csr_addr == machine_mode_pkg::MIE_ADDR) begin
        msie <= wr_value[machine_mode_pkg::MIE_MSIE_BIT];
        mtie <= wr_value[machine_mode_pkg::MIE_MTIE_BIT];
      end

      if (csr_op && csr_addr == machine_mode_pkg::MSCRATCH_ADDR) begin
        mscratch <= wr_value;
      end

      if (mepc_rup) begin
        mepc <= mepc_next;
      end else if (csr_op && csr_addr == machine_mode_pkg::MEPC_ADDR) begin
        mepc <= wr_value;
      end

      if (mcause_rup) begin
        mcause <= mcause_next;
      end else if (csr_op && csr_addr == machine_mode_pkg::MCAUSE_ADDR) begin
        mcause <= wr_value;
      end

      if (mbadaddr_rup) begin
        mbadaddr <= mbadaddr_next;
      end else if (csr_op && csr_addr == machine_mode_pkg::MBADADDR_ADDR) begin
        mbadaddr <= wr_value;
      end

      // Last accepted tohost word
      if (tohost_push) begin
        mtohost <= wr_value;
      end

      // Host delivery overrides a software clear
      if (fromhost_valid) begin
        mfromhost <= fromhost_data;
      end else if (csr_op && csr_addr == machine_mode_pkg::MFROMHOST_ADDR) begin
        mfromhost <= wr_value;
      end
    end
  end

endmodule

`default_nettype wire

// File: source/machine_mode_pkg.sv
// Shared CSR addresses, cause codes, bit positions and types for the machine-mode privilege unit
`default_nettype none

package machine_mode_pkg;

  // Plain vector types with a fixed meaning
  typedef logic [31:0] word_t;
  typedef logic [11:0] csr_addr_t;
  // Bit 31 set marks an interrupt
  typedef logic [31:0] cause_t;

  // Machine information registers
  localparam csr_addr_t MCPUID_ADDR    = 12'hF00;
  localparam csr_addr_t MIMPID_ADDR    = 12'hF01;
  localparam csr_addr_t MHARTID_ADDR   = 12'hF10;

  // Machine trap setup
  localparam csr_addr_t MSTATUS_ADDR   = 12'h300;
  localparam csr_addr_t MTVEC_CSR_ADDR = 12'h301;
  localparam csr_addr_t MTDELEG_ADDR   = 12'h302;
  localparam csr_addr_t MIE_ADDR       = 12'h304;

  // Machine trap handling
  localparam csr_addr_t MSCRATCH_ADDR  = 12'h340;
  localparam csr_addr_t MEPC_ADDR      = 12'h341;
  localparam csr_addr_t MCAUSE_ADDR    = 12'h342;
  localparam csr_addr_t MBADADDR_ADDR  = 12'h343;
  localparam csr_addr_t MIP_ADDR       = 12'h344;

  // Non-standard host registers
  localparam csr_addr_t MTOHOST_ADDR   = 12'h780;
  localparam csr_addr_t MFROMHOST_ADDR = 12'h781;

  // Protection, counter deltas and timers are absent and read zero
  localparam int NUM_ZERO_ADDRS = 11;
  localparam csr_addr_t ZERO_ADDRS [NUM_ZERO_ADDRS] = '{
    12'h380, 12'h381, 12'h382, 12'h383, 12'h384, 12'h385,
    12'hB01, 12'hB81,
    12'h321, 12'h701, 12'h741
  };

  // Fixed trap vector
  localparam word_t MTVEC_ADDR   = 32'h0000_0100;
  // Base field zero means RV32, bit 8 is the I extension
  localparam word_t MCPUID_VALUE = 32'h0000_0100;

  // Cause codes
  localparam cause_t CAUSE_SOFT_INT         = 32'h8000_0000;
  localparam cause_t CAUSE_TIMER_INT        = 32'h8000_0001;
  localparam cause_t CAUSE_ILLEGAL_INSN     = 32'd2;
  localparam cause_t CAUSE_BREAKPOINT       = 32'd3;
  localparam cause_t CAUSE_LOAD_MISALIGNED  = 32'd4;
  localparam cause_t CAUSE_STORE_MISALIGNED = 32'd6;
  localparam cause_t CAUSE_ECALL_M          = 32'd11;

  // Bit positions inside mstatus, mie and mip
  localparam int MSTATUS_IE_BIT  = 0;
  localparam int MSTATUS_IE1_BIT = 3;
  localparam int MIE_MSIE_BIT    = 3;
  localparam int MIE_MTIE_BIT    = 7;
  localparam int MIP_MSIP_BIT    = 3;
  localparam int MIP_MTIP_BIT    = 7;

  // Host channel sizing
  localparam int TOHOST_CREDITS = 2;
  localparam int TOHOST_DEPTH   = 4;

endpackage

`default_nettype wire

// File: source/priv_unit.sv
// Top of the machine-mode privilege unit joining the CSR file, trap control and host link
`timescale 1ns/1ps
`default_nettype none

module priv_unit (
  input  wire logic                        CLK,
  input  wire logic                        nRST,
  input  wire machine_mode_pkg::csr_addr_t csr_addr,
  input  wire machine_mode_pkg::word_t     csr_wdata,
  input  wire logic                        csr_swap,
  input  wire logic                        csr_set,
  input  wire logic                        csr_clr,
  input  wire logic                        exc_illegal,
  input  wire logic                        exc_breakpoint,
  input  wire logic                        exc_ecall,
  input  wire logic                        exc_load_misaligned,
  input  wire logic                        exc_store_misaligned,
  input  wire machine_mode_pkg::word_t     exc_pc,
  input  wire machine_mode_pkg::word_t     exc_badaddr,
  input  wire logic                        mret,
  input  wire logic                        irq_soft,
  input  wire logic                        irq_timer,
  input  wire logic                        host_credit,
  input  wire logic                        fromhost_valid,
  input  wire machine_mode_pkg::word_t     fromhost_data,
  output      machine_mode_pkg::word_t     csr_rdata,
  output      logic                        invalid_csr,
  output      logic                        csr_busy,
  output      logic                        trap_taken,
  output      machine_mode_pkg::word_t     redirect_pc,
  output      logic                        host_valid,
  output      machine_mode_pkg::word_t     host_data
);

  // Privilege update strobes
  logic                     mcause_rup, mepc_rup, mbadaddr_rup;
  logic                     ie_rup, ie_next, ie1_next;
  machine_mode_pkg::cause_t mcause_next;
  machine_mode_pkg::word_t  mepc_next, mbadaddr_next;
  // CSR state seen by the controller
  logic                     mstatus_ie, mstatus_ie1;
  machine_mode_pkg::word_t  mie, mip, mepc;
  // Host queue hookup
  logic                     tohost_full, tohost_push;
  machine_mode_pkg::word_t  tohost_data;

  csr_rfile csr_rfile_i (
    .CLK, .nRST,
    .csr_addr, .csr_wdata, .csr_swap, .csr_set, .csr_clr,
    .csr_rdata, .invalid_csr, .csr_busy,
    .irq_soft, .irq_timer,
    .mcause_rup, .mcause_next, .mepc_rup, .mepc_next,
    .mbadaddr_rup, .mbadaddr_next, .ie_rup, .ie_next, .ie1_next,
    .mstatus_ie, .mstatus_ie1, .mie, .mip, .mepc,
    .tohost_full, .tohost_push, .tohost_data,
    .fromhost_valid, .fromhost_data
  );

  prv_control prv_control_i (
    .exc_illegal, .exc_breakpoint, .exc_ecall,
    .exc_load_misaligned, .exc_store_misaligned,
    .invalid_csr, .mret, .exc_pc, .exc_badaddr,
    .mstatus_ie, .mstatus_ie1, .mie, .mip, .mepc,
    .trap_taken, .redirect_pc,
    .mcause_rup, .mcause_next, .mepc_rup, .mepc_next,
    .mbadaddr_rup, .mbadaddr_next, .ie_rup, .ie_next, .ie1_next
  );

  tohost_link #(
    .CREDITS (machine_mode_pkg::TOHOST_CREDITS),
    .DEPTH   (machine_mode_pkg::TOHOST_DEPTH)
  ) tohost_link_i (
    .CLK, .nRST,
    .tohost_push, .tohost_data, .host_credit,
    .tohost_full, .host_valid, .host_data
  );

endmodule

`default_nettype wire

// File: source/prv_control.sv
// Trap prioritiser and cause encoder driving trap entry and mret updates into the CSR file
`timescale 1ns/1ps
`default_nettype none

module prv_control (
  input  wire logic                     exc_illegal,
  input  wire logic                     exc_breakpoint,
  input  wire logic                     exc_ecall,
  input  wire logic                     exc_load_misaligned,
  input  wire logic                     exc_store_misaligned,
  input  wire logic                     invalid_csr,
  input  wire logic                     mret,
  input  wire machine_mode_pkg::word_t  exc_pc,
  input  wire machine_mode_pkg::word_t  exc_badaddr,
  input  wire logic                     mstatus_ie,
  input  wire logic                     mstatus_ie1,
  input  wire machine_mode_pkg::word_t  mie,
  input  wire machine_mode_pkg::word_t  mip,
  input  wire machine_mode_pkg::word_t  mepc,
  output      logic                     trap_taken,
  output      machine_mode_pkg::word_t  redirect_pc,
  output      logic                     mcause_rup,
  output      machine_mode_pkg::cause_t mcause_next,
  output      logic                     mepc_rup,
  output      machine_mode_pkg::word_t  mepc_next,
  output      logic                     mbadaddr_rup,
  output      machine_mode_pkg::word_t  mbadaddr_next,
  output      logic                     ie_rup,
  output      logic                     ie_next,
  output      logic                     ie1_next
);

  logic soft_pend, timer_pend;
  logic exc_any;
  logic misaligned;
  logic mret_taken;

  // Interrupt needs global enable plus its own enable and pending bit
  assign soft_pend  = mstatus_ie & mie[machine_mode_pkg::MIE_MSIE_BIT] &
                      mip[machine_mode_pkg::MIP_MSIP_BIT];
  assign timer_pend = mstatus_ie & mie[machine_mode_pkg::MIE_MTIE_BIT] &
                      mip[machine_mode_pkg::MIP_MTIP_BIT];

  assign exc_any = exc_illegal | invalid_csr | exc_breakpoint | exc_ecall |
                   exc_load_misaligned | exc_store_misaligned;

  // Priority encoder, interrupts first
  always_comb begin
    misaligned  = 1'b0;
    mcause_next = machine_mode_pkg::CAUSE_ECALL_M;
    if (soft_pend) begin
      mcause_next = machine_mode_pkg::CAUSE_SOFT_INT;
    end else if (timer_pend) begin
      mcause_next = machine_mode_pkg::CAUSE_TIMER_INT;
    end else if (exc_illegal || invalid_csr) begin
      mcause_next = machine_mode_pkg::CAUSE_ILLEGAL_INSN;
    end else if (exc_breakpoint) begin
      mcause_next = machine_mode_pkg::CAUSE_BREAKPOINT;
    end else if (exc_load_misaligned) begin
      mcause_next = machine_mode_pkg::CAUSE_LOAD_MISALIGNED;
      misaligned  = 1'b1;
    end else if (exc_store_misaligned) begin
      mcause_next = machine_mode_pkg::CAUSE_STORE_MISALIGNED;
      misaligned  = 1'b1;
    end
  end

  assign trap_taken = soft_pend | timer_pend | exc_any;
  // A trap in the same cycle cancels the mret
  assign mret_taken = mret & ~trap_taken;

  assign redirect_pc = trap_taken ? machine_mode_pkg::MTVEC_ADDR :
                       mret_taken ? mepc : '0;

  assign mcause_rup    = trap_taken;
  assign mepc_rup      = trap_taken;
  assign mepc_next     = exc_pc;
  // Bad address only kept for the misaligned causes
  assign mbadaddr_rup  = trap_taken & misaligned;
  assign mbadaddr_next = exc_badaddr;

  // Trap pushes the enable stack, mret pops it
  assign ie_rup   = trap_taken | mret_taken;
  assign ie_next  = trap_taken ? 1'b0 : mstatus_ie1;
  assign ie1_next = trap_taken ? mstatus_ie : 1'b1;

endmodule

`default_nettype wire

// File: source/tohost_link.sv
// Queue for tohost words with credit-based flow control toward the external host
`timescale 1ns/1ps
`default_nettype none

module tohost_link #(
  parameter int CREDITS = machine_mode_pkg::TOHOST_CREDITS,
  parameter int DEPTH   = machine_mode_pkg::TOHOST_DEPTH
) (
  input  wire logic                    CLK,
  input  wire logic                    nRST,
  input  wire logic                    tohost_push,
  input  wire machine_mode_pkg::word_t tohost_data,
  input  wire logic                    host_credit,
  output      logic                    tohost_full,
  output      logic                    host_valid,
  output      machine_mode_pkg::word_t host_data
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam int CRD_W = $clog2(CREDITS + 1);

  // Queue storage
  machine_mode_pkg::word_t mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr, rd_ptr;
  logic [CNT_W-1:0] count;
  logic [CRD_W-1:0] credits;
  logic             send;

  // Send whenever a word waits and the host has room
  assign send        = (count != '0) && (credits != '0);
  assign host_valid  = send;
  assign host_data   = mem[rd_ptr];
  assign tohost_full = (count == CNT_W'(DEPTH));

  always_ff @(posedge CLK) begin
    if (tohost_push) begin
      mem[wr_ptr] <= tohost_data;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      credits <= CRD_W'(CREDITS);
    end else begin
      // Wrap explicitly so any depth works
      if (tohost_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (send) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({tohost_push, send})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // Credit back in a send cycle cancels out
      case ({send, host_credit})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: sources.f
source/machine_mode_pkg.sv
source/csr_rfile.sv
source/prv_control.sv
source/tohost_link.sv
source/priv_unit.sv
sim/tb_clock_gen.sv
sim/priv_unit_props.sv
sim/priv_unit_tb.sv
